// ==== dm_cfg.svh ====
// debug module configuration
// buffer sizes, bus widths, register addresses and fixed field values
`ifndef DM_CFG_SVH
`define DM_CFG_SVH

`define DM_PROGBUF_WORDS 4
`define DM_DATA_WORDS    4
`define DM_WORD_W        32
`define DM_DMI_ADDR_W    7
`define DM_SRI_ADDR_W    3     // word index into progbuf then data

`define DM_VERSION       4'd3  // debug spec 1.0

`define DM_ADDR_DATA0    7'h04
`define DM_ADDR_PROGBUF0 7'h20

`define DM_GPR_FIRST     16'h1000
`define DM_GPR_LAST      16'h101f

`endif

// ==== dmi_pkg.sv ====
// DMI transport types
// request and response ops, bus beats and the decoded register access
`default_nettype none

`include "dm_cfg.svh"

package dmi_pkg;

    typedef enum logic [1:0] {
        DMI_NOP  = 2'd0,
        DMI_RD   = 2'd1,
        DMI_WR   = 2'd2,
        DMI_RSVD = 2'd3
    } dmi_op_e;

    typedef enum logic [1:0] {
        DMI_OK     = 2'd0,
        DMI_FAILED = 2'd2
    } dmi_resp_e;

    typedef struct packed {
        logic [`DM_DMI_ADDR_W-1:0] addr;
        logic [`DM_WORD_W-1:0]     data;
        dmi_op_e                   op;
    } dmi_req_t;

    typedef struct packed {
        logic [`DM_WORD_W-1:0] data;
        dmi_resp_e             op;
    } dmi_resp_t;

    // one register access, strobes valid for a single cycle
    typedef struct packed {
        logic                      we;
        logic                      re;
        logic [`DM_DMI_ADDR_W-1:0] addr;
        logic [`DM_WORD_W-1:0]     wdata;
    } dmi_access_t;

    typedef enum logic [`DM_DMI_ADDR_W-1:0] {
        ADDR_DATA0      = `DM_ADDR_DATA0,
        ADDR_DMCONTROL  = 7'h10,
        ADDR_DMSTATUS   = 7'h11,
        ADDR_HARTINFO   = 7'h12,
        ADDR_ABSTRACTCS = 7'h16,
        ADDR_COMMAND    = 7'h17,
        ADDR_SBCS       = 7'h38
    } dm_addr_e;

endpackage

`default_nettype wire

// ==== dm_pkg.sv ====
// debug register layouts and hart side types
`default_nettype none

`include "dm_cfg.svh"

package dm_pkg;

    typedef enum logic [2:0] {
        CMDERR_NONE          = 3'd0,
        CMDERR_NOT_SUPPORTED = 3'd2
    } cmderr_e;

    typedef struct packed {
        logic       haltreq;
        logic       resumereq;      // write only
        logic       hartreset;
        logic       ackhavereset;
        logic       ackunavail;
        logic       hasel;
        logic [9:0] hartsello;
        logic [9:0] hartselhi;
        logic       setkeepalive;
        logic       clrkeepalive;
        logic       setresethaltreq;
        logic       clrresethaltreq;
        logic       ndmreset;
        logic       dmactive;
    } dmcontrol_t;

    typedef struct packed {
        logic [6:0] zero1;
        logic       ndmresetpending;
        logic       stickyunavail;
        logic       impebreak;
        logic [1:0] zero0;
        logic       allhavereset;
        logic       anyhavereset;
        logic       allresumeack;
        logic       anyresumeack;
        logic       allnonexistent;
        logic       anynonexistent;
        logic       allunavail;
        logic       anyunavail;
        logic       allrunning;
        logic       anyrunning;
        logic       allhalted;
        logic       anyhalted;
        logic       authenticated;
        logic       authbusy;
        logic       hasresethaltreq;
        logic       confstrptrvalid;
        logic [3:0] version;
    } dmstatus_t;

    typedef struct packed {
        logic [7:0]  zero1;
        logic [3:0]  nscratch;
        logic [2:0]  zero0;
        logic        dataaccess;
        logic [3:0]  datasize;
        logic [11:0] dataaddr;
    } hartinfo_t;

    typedef struct packed {
        logic [2:0]  zero3;
        logic [4:0]  progbufsize;
        logic [10:0] zero2;
        logic        busy;
        logic        relaxedpriv;
        cmderr_e     cmderr;
        logic [3:0]  zero1;
        logic [3:0]  datacount;
    } abstractcs_t;

    // access register layout, control split off above regno
    typedef struct packed {
        logic [7:0]  cmdtype;
        logic [7:0]  control;
        logic [15:0] regno;
    } command_t;

    typedef struct packed {
        logic halted;
        logic running;
        logic resume_ack;
        logic havereset;
        logic unavail;
    } hart_status_t;

    typedef struct packed {
        logic                      en;
        logic                      we;
        logic [`DM_WORD_W/8-1:0]   be;
        logic [`DM_SRI_ADDR_W-1:0] addr;
        logic [`DM_WORD_W-1:0]     wdata;
    } sri_req_t;

endpackage

`default_nettype wire

// ==== dm_dmi_fsm.sv ====
// DMI front end
// accepts one request at a time and holds the registered response until taken
`timescale 1ns/1ns
`default_nettype none

`include "dm_cfg.svh"

module dm_dmi_fsm
    import dmi_pkg::*;
(
    input  wire logic                  clk_i,
    input  wire logic                  rstn_i,

    input  wire dmi_req_t              dmi_req_i,
    input  wire logic                  req_valid_i,
    output logic                       req_ready_o,

    output dmi_resp_t                  dmi_resp_o,
    output logic                       resp_valid_o,
    input  wire logic                  resp_ready_i,

    output dmi_access_t                access_o,      // to both register blocks
    input  wire logic [`DM_WORD_W-1:0] ctrl_rdata_i,
    input  wire logic [`DM_WORD_W-1:0] buf_rdata_i
);

    typedef enum logic {
        IDLE,
        RESP
    } state_e;

    state_e    state_q;
    state_e    state_d;
    logic      accept;
    dmi_resp_t resp_q;

    assign req_ready_o  = (state_q == IDLE);
    assign resp_valid_o = (state_q == RESP);
    assign accept       = req_valid_i & req_ready_o;

    // strobes only on the acceptance cycle
    always_comb begin
        access_o.we    = accept && (dmi_req_i.op == DMI_WR);
        access_o.re    = accept && (dmi_req_i.op == DMI_RD);
        access_o.addr  = dmi_req_i.addr;
        access_o.wdata = dmi_req_i.data;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    state_d = RESP;
                end
            end
            RESP: begin
                if (resp_ready_i) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // blocks return zero unless read strobed, so writes and nops answer zero data
    always_ff @(posedge clk_i) begin
        if (accept) begin
            resp_q.data <= ctrl_rdata_i | buf_rdata_i;
            resp_q.op   <= (dmi_req_i.op == DMI_RSVD) ? DMI_FAILED : DMI_OK;
        end
    end

    assign dmi_resp_o = resp_q; // stable while waiting on resp_ready_i

endmodule

`default_nettype wire

// ==== dm_ctrl_regs.sv ====
// debug control and status registers
// run control toward the hart, status readback and abstract command checking
`timescale 1ns/1ns
`default_nettype none

`include "dm_cfg.svh"

module dm_ctrl_regs
    import dmi_pkg::*, dm_pkg::*;
(
    input  wire logic         clk_i,
    input  wire logic         rstn_i,
    input  wire dmi_access_t  access_i,
    input  wire hart_status_t hart_i,
    output logic [`DM_WORD_W-1:0] rdata_o,
    output logic              halt_req_o,
    output logic              resume_req_o
);

    logic        dmactive_q;
    logic        haltreq_q;
    logic        resumereq_q;
    cmderr_e     cmderr_q;

    dmcontrol_t  ctl_wr;
    abstractcs_t cs_wr;
    command_t    cmd_wr;
    logic        cmd_ok;

    dmcontrol_t  ctl_rd;
    dmstatus_t   status_rd;
    hartinfo_t   info_rd;
    abstractcs_t cs_rd;

    assign ctl_wr = access_i.wdata;
    assign cs_wr  = access_i.wdata;
    assign cmd_wr = access_i.wdata;

    // only gpr register access is supported
    assign cmd_ok = (cmd_wr.cmdtype == 8'd0) &&
                    (cmd_wr.regno >= `DM_GPR_FIRST) && (cmd_wr.regno <= `DM_GPR_LAST);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            dmactive_q  <= 1'b0;
            haltreq_q   <= 1'b0;
            resumereq_q <= 1'b0;
            cmderr_q    <= CMDERR_NONE;
        end else if (access_i.we) begin
            case (access_i.addr)
                ADDR_DMCONTROL: begin
                    dmactive_q <= ctl_wr.dmactive;
                    haltreq_q  <= ctl_wr.haltreq;
                    if (!(haltreq_q | ctl_wr.haltreq)) begin
                        resumereq_q <= ctl_wr.resumereq;  // halt takes precedence
                    end
                end
                ADDR_ABSTRACTCS: begin
                    cmderr_q <= cmderr_e'(cmderr_q & ~cs_wr.cmderr); // write 1 to clear
                end
                ADDR_COMMAND: begin
                    if (cmderr_q == CMDERR_NONE && !cmd_ok) begin
                        cmderr_q <= CMDERR_NOT_SUPPORTED;
                    end
                end
                default: ;
            endcase
        end
    end

    assign halt_req_o   = haltreq_q;
    assign resume_req_o = resumereq_q;

    always_comb begin
        ctl_rd          = '0;
        ctl_rd.dmactive = dmactive_q;
        ctl_rd.haltreq  = haltreq_q;

        // single hart, so each all/any pair is that hart's level
        status_rd                = '0;
        status_rd.allhavereset   = hart_i.havereset;
        status_rd.anyhavereset   = hart_i.havereset;
        status_rd.allresumeack   = hart_i.resume_ack;
        status_rd.anyresumeack   = hart_i.resume_ack;
        status_rd.allunavail     = hart_i.unavail;
        status_rd.anyunavail     = hart_i.unavail;
        status_rd.allrunning     = hart_i.running;
        status_rd.anyrunning     = hart_i.running;
        status_rd.allhalted      = hart_i.halted;
        status_rd.anyhalted      = hart_i.halted;
        status_rd.authenticated  = 1'b1;
        status_rd.version        = `DM_VERSION;

        info_rd            = '0;
        info_rd.dataaccess = 1'b1;
        info_rd.datasize   = 4'(`DM_DATA_WORDS);

        cs_rd             = '0;
        cs_rd.progbufsize = 5'(`DM_PROGBUF_WORDS);
        cs_rd.datacount   = 4'(`DM_DATA_WORDS);
        cs_rd.cmderr      = cmderr_q;
    end

    always_comb begin
        rdata_o = '0;
        if (access_i.re) begin
            case (access_i.addr)
                ADDR_DMCONTROL:  rdata_o = ctl_rd;
                ADDR_DMSTATUS:   rdata_o = status_rd;
                ADDR_HARTINFO:   rdata_o = info_rd;
                ADDR_ABSTRACTCS: rdata_o = cs_rd;
                default:         rdata_o = '0;   // sbcs too, no system bus
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== dm_buffers.sv ====
// program and data buffers
// shared between the DMI and the hart side SRI port, SRI writes win
`timescale 1ns/1ns
`default_nettype none

`include "dm_cfg.svh"

module dm_buffers
    import dmi_pkg::*, dm_pkg::*;
(
    input  wire logic             clk_i,
    input  wire logic             rstn_i,
    input  wire dmi_access_t      access_i,
    input  wire sri_req_t         sri_i,
    output logic [`DM_WORD_W-1:0] rdata_o,
    output logic [`DM_WORD_W-1:0] sri_rdata_o
);

    localparam int NWORDS = `DM_PROGBUF_WORDS + `DM_DATA_WORDS;

    logic [NWORDS-1:0][`DM_WORD_W-1:0] buf_q;   // progbuf first, then data

    logic [`DM_DMI_ADDR_W-1:0] data_off;
    logic [`DM_DMI_ADDR_W-1:0] prog_off;
    logic                      data_hit;
    logic                      prog_hit;
    logic [`DM_SRI_ADDR_W-1:0] dmi_idx;
    logic                      sri_wr;
    logic                      dmi_wr;

    // offsets wrap below the base, so one compare covers the range
    assign data_off = access_i.addr - `DM_ADDR_DATA0;
    assign prog_off = access_i.addr - `DM_ADDR_PROGBUF0;
    assign data_hit = data_off < `DM_DMI_ADDR_W'(`DM_DATA_WORDS);
    assign prog_hit = prog_off < `DM_DMI_ADDR_W'(`DM_PROGBUF_WORDS);
    assign dmi_idx  = data_hit ? `DM_SRI_ADDR_W'(`DM_PROGBUF_WORDS) + data_off[`DM_SRI_ADDR_W-1:0]
                               : prog_off[`DM_SRI_ADDR_W-1:0];

    assign sri_wr = sri_i.en & sri_i.we;
    // a colliding sri write drops the dmi word entirely
    assign dmi_wr = access_i.we & (data_hit | prog_hit) & ~(sri_wr && sri_i.addr == dmi_idx);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            buf_q <= '0;
        end else begin
            if (dmi_wr) begin
                buf_q[dmi_idx] <= access_i.wdata;
            end
            if (sri_wr) begin
                for (int b = 0; b < `DM_WORD_W/8; b++) begin
                    if (sri_i.be[b]) begin
                        buf_q[sri_i.addr][8*b +: 8] <= sri_i.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    assign rdata_o     = (access_i.re && (data_hit || prog_hit)) ? buf_q[dmi_idx] : '0;
    assign sri_rdata_o = sri_i.en ? buf_q[sri_i.addr] : '0;

endmodule

`default_nettype wire

// ==== riscv_dm_top.sv ====
// debug module for a single hart
// DMI front end, control registers and shared buffers
`timescale 1ns/1ns
`default_nettype none

`include "dm_cfg.svh"

module riscv_dm_top
    import dmi_pkg::*, dm_pkg::*;
(
    input  wire logic             clk_i,
    input  wire logic             rstn_i,

    input  wire dmi_req_t         dmi_req_i,
    input  wire logic             req_valid_i,
    output logic                  req_ready_o,
    output dmi_resp_t             dmi_resp_o,
    output logic                  resp_valid_o,
    input  wire logic             resp_ready_i,

    input  wire hart_status_t     hart_i,
    output logic                  halt_req_o,
    output logic                  resume_req_o,

    input  wire sri_req_t         sri_i,
    output logic [`DM_WORD_W-1:0] sri_rdata_o
);

    dmi_access_t           access;
    logic [`DM_WORD_W-1:0] ctrl_rdata;
    logic [`DM_WORD_W-1:0] buf_rdata;

    dm_dmi_fsm u_dmi_fsm (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .dmi_req_i    (dmi_req_i),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .dmi_resp_o   (dmi_resp_o),
        .resp_valid_o (resp_valid_o),
        .resp_ready_i (resp_ready_i),
        .access_o     (access),
        .ctrl_rdata_i (ctrl_rdata),
        .buf_rdata_i  (buf_rdata)
    );

    dm_ctrl_regs u_ctrl_regs (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .access_i     (access),
        .hart_i       (hart_i),
        .rdata_o      (ctrl_rdata),
        .halt_req_o   (halt_req_o),
        .resume_req_o (resume_req_o)
    );

    dm_buffers u_buffers (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .access_i    (access),
        .sri_i       (sri_i),
        .rdata_o     (buf_rdata),
        .sri_rdata_o (sri_rdata_o)
    );

endmodule

`default_nettype wire

// ==== tb_riscv_dm.sv ====
// testbench for the single hart debug module
// random DMI and SRI traffic checked against a register model
`timescale 1ns/1ns
`default_nettype none

`include "dm_cfg.svh"

module tb_riscv_dm
    import dmi_pkg::*, dm_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 300 * 24;   // 300 transactions, 24 cycles each at most
    localparam int NWORDS         = `DM_PROGBUF_WORDS + `DM_DATA_WORDS;

    logic                  clk_i;
    logic                  rstn_i;
    dmi_req_t              dmi_req_i;
    logic                  req_valid_i;
    logic                  req_ready_o;
    dmi_resp_t             dmi_resp_o;
    logic                  resp_valid_o;
    logic                  resp_ready_i;
    hart_status_t          hart_i;
    logic                  halt_req_o;
    logic                  resume_req_o;
    sri_req_t              sri_i;
    logic [`DM_WORD_W-1:0] sri_rdata_o;

    logic [31:0] lfsr_q;
    int          errors;
    int          checks;
    int          cycles;

    // register model, progbuf words first and then data words
    logic [`DM_WORD_W-1:0] buf_m [0:NWORDS-1];
    logic                  haltreq_m;
    logic                  resumereq_m;
    logic                  dmactive_m;
    logic [2:0]            cmderr_m;

    riscv_dm_top u_riscv_dm_top (.*);

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, a DMI handshake never completed", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] lfsr_bits(input int nbits);
        logic [31:0] val;
        logic        lsb;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            lsb    = lfsr_q[0];
            lfsr_q = lfsr_q >> 1;
            if (lsb) begin
                lfsr_q = lfsr_q ^ 32'h80200003;
            end
            val = {val[30:0], lsb};
        end
        return val;
    endfunction

    function automatic int buf_index(input logic [6:0] addr);
        int off;
        off = int'(addr) - int'(`DM_ADDR_PROGBUF0);
        if (off >= 0 && off < `DM_PROGBUF_WORDS) begin
            return off;
        end
        off = int'(addr) - int'(`DM_ADDR_DATA0);
        if (off >= 0 && off < `DM_DATA_WORDS) begin
            return `DM_PROGBUF_WORDS + off;
        end
        return -1;
    endfunction

    function automatic logic [6:0] buf_addr(input int idx);
        if (idx < `DM_PROGBUF_WORDS) begin
            return 7'(int'(`DM_ADDR_PROGBUF0) + idx);
        end
        return 7'(int'(`DM_ADDR_DATA0) + idx - `DM_PROGBUF_WORDS);
    endfunction

    function automatic logic is_known(input logic [6:0] addr);
        return buf_index(addr) >= 0 ||
               addr inside {ADDR_DMCONTROL, ADDR_DMSTATUS, ADDR_HARTINFO,
                            ADDR_ABSTRACTCS, ADDR_COMMAND, ADDR_SBCS};
    endfunction

    function automatic logic [31:0] model_read(input logic [6:0] addr);
        int          idx;
        logic [31:0] val;
        idx = buf_index(addr);
        val = '0;
        if (idx >= 0) begin
            val = buf_m[3'(idx)];
        end else begin
            case (addr)
                ADDR_DMCONTROL:  val = {haltreq_m, 30'b0, dmactive_m};
                ADDR_DMSTATUS:   val = {12'b0, {2{hart_i.havereset}}, {2{hart_i.resume_ack}},
                                        2'b00, {2{hart_i.unavail}}, {2{hart_i.running}},
                                        {2{hart_i.halted}}, 1'b1, 3'b000, 4'(`DM_VERSION)};
                ADDR_HARTINFO:   val = {15'b0, 1'b1, 4'(`DM_DATA_WORDS), 12'b0};
                ADDR_ABSTRACTCS: val = {3'b0, 5'(`DM_PROGBUF_WORDS), 13'b0, cmderr_m,
                                        4'b0, 4'(`DM_DATA_WORDS)};
                default:         val = '0;
            endcase
        end
        return val;
    endfunction

    function automatic void apply_write(input logic [6:0] addr, input logic [31:0] data);
        int idx;
        idx = buf_index(addr);
        if (idx >= 0) begin
            buf_m[3'(idx)] = data;
        end else if (addr == ADDR_DMCONTROL) begin
            dmactive_m = data[0];
            if (!haltreq_m && !data[31]) begin
                resumereq_m = data[30];     // only with no halt old or new
            end
            haltreq_m = data[31];
        end else if (addr == ADDR_ABSTRACTCS) begin
            cmderr_m = cmderr_m & ~data[10:8];
        end else if (addr == ADDR_COMMAND && cmderr_m == 3'd0) begin
            if (data[31:24] != 8'd0 || data[15:0] < `DM_GPR_FIRST ||
                data[15:0] > `DM_GPR_LAST) begin
                cmderr_m = 3'd2;
            end
        end
    endfunction

    function automatic void apply_sri_write(input logic [2:0] idx, input logic [3:0] be,
                                            input logic [31:0] data);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                buf_m[idx][8*b +: 8] = data[8*b +: 8];
            end
        end
    endfunction

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL %s expected %h actual %h", name, exp, act);
        end
    endtask

    // one request, response taken under random back-pressure
    task automatic dmi_xfer(input logic [6:0] addr, input logic [31:0] data, input dmi_op_e op,
                            output dmi_resp_t resp);
        dmi_resp_t held;
        logic      take;
        logic      done;
        dmi_req_i.addr = addr;
        dmi_req_i.data = data;
        dmi_req_i.op   = op;
        req_valid_i    = 1'b1;
        resp_ready_i   = 1'b0;
        while (!req_ready_o) begin
            @(negedge clk_i);
        end
        checks++;
        if (resp_valid_o) begin
            errors++;
            $display("response valid while the DMI was ready for a request");
        end
        @(negedge clk_i);
        sri_i        = '0;          // a paired sri access lasts one cycle
        dmi_req_i.op = DMI_NOP;     // left on the bus, must not be taken
        checks++;
        if (!resp_valid_o || req_ready_o) begin
            errors++;
            $display("response valid did not rise one cycle after acceptance");
        end
        held = dmi_resp_o;
        done = 1'b0;
        while (!done) begin
            take         = (lfsr_bits(1) != 0);
            resp_ready_i = take;
            @(negedge clk_i);
            checks++;
            if (take) begin
                done = 1'b1;
                if (resp_valid_o || !req_ready_o) begin
                    errors++;
                    $display("DMI did not return to idle after the response was taken");
                end
            end else if (!resp_valid_o || req_ready_o || dmi_resp_o !== held) begin
                errors++;
                $display("response or ready changed while the host held off");
            end
        end
        resp_ready_i = 1'b0;
        req_valid_i  = 1'b0;
        resp         = held;
    endtask

    task automatic dmi_write(input logic [6:0] addr, input logic [31:0] data);
        dmi_resp_t resp;
        dmi_xfer(addr, data, DMI_WR, resp);
        check_word("write response", 32'(DMI_OK), 32'(resp.op));
        apply_write(addr, data);
    endtask

    task automatic dmi_read_check(input string name, input logic [6:0] addr,
                                  input logic [31:0] exp);
        dmi_resp_t resp;
        dmi_xfer(addr, lfsr_bits(32), DMI_RD, resp);
        check_word({name, " response"}, 32'(DMI_OK), 32'(resp.op));
        check_word(name, exp, resp.data);
    endtask

    task automatic sri_write(input logic [2:0] idx, input logic [3:0] be, input logic [31:0] data);
        sri_i.en    = 1'b1;
        sri_i.we    = 1'b1;
        sri_i.be    = be;
        sri_i.addr  = idx;
        sri_i.wdata = data;
        @(negedge clk_i);
        sri_i = '0;
        apply_sri_write(idx, be, data);
    endtask

    task automatic sri_read_check(input string name, input logic [2:0] idx);
        sri_i.en   = 1'b1;
        sri_i.addr = idx;
        #2;
        check_word(name, buf_m[idx], sri_rdata_o);
        @(negedge clk_i);
        sri_i = '0;
        #2;
        check_word("sri idle read data", 32'd0, sri_rdata_o);
        @(negedge clk_i);
    endtask

    initial begin : main
        logic [2:0]  idx;
        logic [3:0]  be;
        logic [31:0] data;
        logic [6:0]  addr;
        logic [15:0] regno;
        logic [7:0]  cmdtype;
        logic [1:0]  sel;
        dmi_resp_t   resp;

        clk_i        = 1'b0;
        rstn_i       = 1'b0;
        dmi_req_i    = '0;
        req_valid_i  = 1'b0;
        resp_ready_i = 1'b0;
        hart_i       = '0;
        sri_i        = '0;
        lfsr_q       = 32'hee9006bc;
        errors       = 0;
        checks       = 0;
        cycles       = 0;
        haltreq_m    = 1'b0;
        resumereq_m  = 1'b0;
        dmactive_m   = 1'b0;
        cmderr_m     = 3'd0;
        for (int i = 0; i < NWORDS; i++) begin
            buf_m[3'(i)] = '0;
        end

        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;
        check_word("reset req ready", 32'd1, 32'(req_ready_o));
        check_word("reset resp valid", 32'd0, 32'(resp_valid_o));
        check_word("reset halt req", 32'd0, 32'(halt_req_o));
        check_word("reset resume req", 32'd0, 32'(resume_req_o));
        for (int i = 0; i < NWORDS; i++) begin
            sri_read_check("reset buffer", 3'(i));
        end

        // buffer round trip and unknown addresses
        for (int i = 0; i < 32; i++) begin
            idx = 3'(lfsr_bits(3));
            if (lfsr_bits(1) != 0) begin
                dmi_write(buf_addr(int'(idx)), lfsr_bits(32));
            end else begin
                dmi_read_check("buffer round trip", buf_addr(int'(idx)), buf_m[idx]);
            end
        end
        for (int i = 0; i < NWORDS; i++) begin
            dmi_read_check("buffer readback", buf_addr(i), buf_m[3'(i)]);
        end
        for (int i = 0; i < 6; i++) begin
            addr = 7'(lfsr_bits(7));
            while (is_known(addr)) begin
                addr = 7'(lfsr_bits(7));
            end
            dmi_write(addr, lfsr_bits(32));
            dmi_read_check("unknown address", addr, 32'd0);
        end

        // SRI sharing
        for (int i = 0; i < 16; i++) begin
            idx  = 3'(lfsr_bits(3));
            be   = 4'(lfsr_bits(4));
            data = lfsr_bits(32);
            sri_write(idx, be, data);
            dmi_read_check("sri write seen by dmi", buf_addr(int'(idx)), buf_m[idx]);
            idx = 3'(lfsr_bits(3));
            dmi_write(buf_addr(int'(idx)), lfsr_bits(32));
            sri_read_check("dmi write seen by sri", idx);
        end
        for (int i = 0; i < 6; i++) begin
            idx         = 3'(lfsr_bits(3));
            data        = lfsr_bits(32);
            sri_i.en    = 1'b1;
            sri_i.we    = 1'b1;
            sri_i.be    = 4'hf;
            sri_i.addr  = idx;
            sri_i.wdata = data;
            dmi_write(buf_addr(int'(idx)), lfsr_bits(32));
            apply_sri_write(idx, 4'hf, data);   // sri wins on the shared edge
            dmi_read_check("write collision", buf_addr(int'(idx)), buf_m[idx]);
        end

        // run control
        for (int i = 0; i < 20; i++) begin
            data     = lfsr_bits(32);
            data[31] = (lfsr_bits(2) == 0);
            dmi_write(ADDR_DMCONTROL, data);
            check_word("halt req", 32'(haltreq_m), 32'(halt_req_o));
            check_word("resume req", 32'(resumereq_m), 32'(resume_req_o));
            dmi_read_check("dmcontrol readback", ADDR_DMCONTROL, model_read(ADDR_DMCONTROL));
        end

        // status and constants
        for (int i = 0; i < 12; i++) begin
            hart_i = hart_status_t'(5'(lfsr_bits(5)));
            dmi_read_check("dmstatus", ADDR_DMSTATUS, model_read(ADDR_DMSTATUS));
        end
        dmi_read_check("hartinfo", ADDR_HARTINFO, model_read(ADDR_HARTINFO));
        dmi_read_check("abstractcs", ADDR_ABSTRACTCS, model_read(ADDR_ABSTRACTCS));
        dmi_read_check("sbcs", ADDR_SBCS, 32'd0);

        // command errors, sticky until cleared
        for (int i = 0; i < 24; i++) begin
            sel   = 2'(lfsr_bits(2));
            regno = `DM_GPR_FIRST + 16'(lfsr_bits(5));
            if (sel == 2'd2) begin
                regno = (lfsr_bits(1) != 0) ? `DM_GPR_FIRST - 16'd1 : `DM_GPR_LAST + 16'd1;
            end else if (sel == 2'd3) begin
                regno = 16'(lfsr_bits(16));
            end
            cmdtype = (lfsr_bits(2) == 0) ? 8'(lfsr_bits(8)) : 8'd0;
            dmi_write(ADDR_COMMAND, {cmdtype, 8'(lfsr_bits(8)), regno});
            dmi_read_check("cmderr after command", ADDR_ABSTRACTCS, model_read(ADDR_ABSTRACTCS));
            if (lfsr_bits(2) == 0) begin
                dmi_write(ADDR_ABSTRACTCS, lfsr_bits(32));
            end
        end
        dmi_read_check("command reads zero", ADDR_COMMAND, 32'd0);
        dmi_xfer(ADDR_DATA0, lfsr_bits(32), DMI_RSVD, resp);
        check_word("reserved op response", 32'(DMI_FAILED), 32'(resp.op));
        check_word("reserved op data", 32'd0, resp.data);
        dmi_read_check("reserved op writes nothing", ADDR_DATA0, model_read(ADDR_DATA0));
        dmi_xfer(ADDR_DMSTATUS, lfsr_bits(32), DMI_NOP, resp);
        check_word("nop response", 32'(DMI_OK), 32'(resp.op));
        check_word("nop data", 32'd0, resp.data);

        $display("checks %0d errors %0d cycles %0d", checks, errors, cycles);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
dmi_pkg.sv
dm_pkg.sv
dm_dmi_fsm.sv
dm_ctrl_regs.sv
dm_buffers.sv
riscv_dm_top.sv
tb_riscv_dm.sv

// ==== Makefile ====
TOOL       = verilator
FLAGS      = --binary --timing
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_riscv_dm
FILELIST   = list.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then exit 1; fi

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
